//--- rtl/sram_test_consts.svh
`ifndef SRAM_TEST_CONSTS_SVH
`define SRAM_TEST_CONSTS_SVH

// Bank organisation
`define SRAM_NUM_MACROS 4
`define SRAM_DATA_W     32

// Word address inside one macro, and the global one with the macro index on top
`define SRAM_WORD_AW    8
`define SRAM_ADDR_W     10

// Scan command is write flag, mask, address and data
`define SCAN_CMD_W      47

`endif

//--- rtl/sram_test_pkg.sv
`default_nettype none

`include "sram_test_consts.svh"

package sram_test_pkg;

   typedef logic [`SRAM_DATA_W-1:0]   mem_word_t;
   typedef logic [`SRAM_DATA_W/8-1:0] mem_mask_t;
   typedef logic [`SRAM_ADDR_W-1:0]   mem_addr_t;
   typedef logic [`SRAM_WORD_AW-1:0]  macro_addr_t;

   // APB port sequencing
   typedef enum logic [1:0] {
      APB_IDLE,
      APB_WAIT_GNT,
      APB_WAIT_DATA
   } apb_state_t;

   // Scan access sequencing
   typedef enum logic [1:0] {
      SCAN_SHIFT,
      SCAN_REQ,
      SCAN_WAIT_DATA
   } scan_state_t;

endpackage

`default_nettype wire

//--- rtl/sram_macro.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_test_consts.svh"

module sram_macro
   import sram_test_pkg::*;
(
   input  wire              clk,
   input  wire              csb_i,
   input  wire              web_i,
   input  wire mem_mask_t   wmask_i,
   input  wire macro_addr_t addr_i,
   input  wire mem_word_t   din_i,
   output mem_word_t        dout_o
);

   localparam int DEPTH   = 2 ** `SRAM_WORD_AW;
   localparam int N_BYTES = `SRAM_DATA_W / 8;

   mem_word_t mem_q [DEPTH];

   // Chip select and write enable are both active low
   always_ff @(posedge clk) begin
      if (!csb_i) begin
         if (!web_i) begin
            for (int b = 0; b < N_BYTES; b++) begin
               if (wmask_i[b]) begin
                  mem_q[addr_i][b*8 +: 8] <= din_i[b*8 +: 8];
               end
            end
         end else begin
            // Read word appears after the clock, like the real macro
            dout_o <= mem_q[addr_i];
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_test_consts.svh"

module sram_bank
   import sram_test_pkg::*;
(
   input  wire            clk,
   input  wire            rstn,
   input  wire            en_i,
   input  wire            we_i,
   input  wire mem_mask_t mask_i,
   input  wire mem_addr_t addr_i,
   input  wire mem_word_t wdata_i,
   output mem_word_t      rdata_o,
   output logic           rvalid_o
);

   localparam int SEL_W = `SRAM_ADDR_W - `SRAM_WORD_AW;

   logic [SEL_W-1:0]            macro_idx;
   macro_addr_t                 word_addr;
   logic [`SRAM_NUM_MACROS-1:0] csb;
   mem_word_t                   macro_dout [`SRAM_NUM_MACROS];
   logic [SEL_W-1:0]            rd_sel_q;
   logic                        rd_pend_q;

   assign macro_idx = addr_i[`SRAM_ADDR_W-1:`SRAM_WORD_AW];
   assign word_addr = addr_i[`SRAM_WORD_AW-1:0];

   genvar g;
   generate
      for (g = 0; g < `SRAM_NUM_MACROS; g++) begin : g_macro
         // One chip select per macro from the upper address bits
         assign csb[g] = ~(en_i && (macro_idx == SEL_W'(g)));

         sram_macro u_macro (
            .clk     (clk),
            .csb_i   (csb[g]),
            .web_i   (~we_i),
            .wmask_i (mask_i),
            .addr_i  (word_addr),
            .din_i   (wdata_i),
            .dout_o  (macro_dout[g])
         );
      end
   endgenerate

   // Remember which macro was read so its output can be picked next cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_pend_q <= 1'b0;
         rd_sel_q  <= '0;
      end else begin
         rd_pend_q <= en_i && !we_i;
         rd_sel_q  <= macro_idx;
      end
   end

   // Capture stage behind the macros
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rdata_o  <= '0;
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= rd_pend_q;
         if (rd_pend_q) begin
            rdata_o <= macro_dout[rd_sel_q];
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
   import sram_test_pkg::*;
(
   input  wire            clk,
   input  wire            rstn,
   // Master 0, APB port
   input  wire            req_m0_i,
   input  wire            we_m0_i,
   input  wire mem_mask_t mask_m0_i,
   input  wire mem_addr_t addr_m0_i,
   input  wire mem_word_t wdata_m0_i,
   output logic           gnt_m0_o,
   output logic           rvalid_m0_o,
   // Master 1, scan controller
   input  wire            req_m1_i,
   input  wire            we_m1_i,
   input  wire mem_mask_t mask_m1_i,
   input  wire mem_addr_t addr_m1_i,
   input  wire mem_word_t wdata_m1_i,
   output logic           gnt_m1_o,
   output logic           rvalid_m1_o,
   output mem_word_t      rdata_o,
   // Bank side
   output logic           en_o,
   output logic           we_o,
   output mem_mask_t      mask_o,
   output mem_addr_t      addr_o,
   output mem_word_t      wdata_o,
   input  wire mem_word_t rdata_i,
   input  wire            rvalid_i
);

   logic       pick_m1;
   logic       last_m1_q;
   logic [1:0] owner_q;

   // Scan wins alone, or on a tie when APB won last time
   assign pick_m1  = req_m1_i && (!req_m0_i || !last_m1_q);
   assign gnt_m1_o = pick_m1;
   assign gnt_m0_o = req_m0_i && !pick_m1;

   assign en_o    = req_m0_i || req_m1_i;
   assign we_o    = pick_m1 ? we_m1_i    : we_m0_i;
   assign mask_o  = pick_m1 ? mask_m1_i  : mask_m0_i;
   assign addr_o  = pick_m1 ? addr_m1_i  : addr_m0_i;
   assign wdata_o = pick_m1 ? wdata_m1_i : wdata_m0_i;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_m1_q <= 1'b0;
         owner_q   <= '0;
      end else begin
         if (en_o) begin
            last_m1_q <= pick_m1;
         end
         // Owner of each access follows it through macro and capture stage
         owner_q <= {owner_q[0], pick_m1};
      end
   end

   assign rdata_o     = rdata_i;
   assign rvalid_m0_o = rvalid_i && !owner_q[1];
   assign rvalid_m1_o = rvalid_i && owner_q[1];

endmodule

`default_nettype wire

//--- rtl/apb_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_test_consts.svh"

module apb_mem_port
   import sram_test_pkg::*;
(
   input  wire                     clk,
   input  wire                     rstn,
   input  wire                     psel_i,
   input  wire                     penable_i,
   input  wire                     pwrite_i,
   input  wire [`SRAM_ADDR_W+1:0]  paddr_i,
   input  wire mem_word_t          pwdata_i,
   input  wire mem_mask_t          pstrb_i,
   output mem_word_t               prdata_o,
   output logic                    pready_o,
   output logic                    req_o,
   output logic                    we_o,
   output mem_mask_t               mask_o,
   output mem_addr_t               addr_o,
   output mem_word_t               wdata_o,
   input  wire                     gnt_i,
   input  wire mem_word_t          rdata_i,
   input  wire                     rvalid_i
);

   apb_state_t state_q;
   logic       wr_done_q;
   logic       rd_done;
   mem_word_t  prdata_q;

   // Bus fields stay stable through the access phase
   assign req_o   = (state_q == APB_WAIT_GNT);
   assign we_o    = pwrite_i;
   assign mask_o  = pstrb_i;
   assign addr_o  = paddr_i[`SRAM_ADDR_W+1:2];
   assign wdata_o = pwdata_i;

   assign rd_done  = (state_q == APB_WAIT_DATA) && rvalid_i;
   assign pready_o = wr_done_q || rd_done;
   assign prdata_o = rd_done ? rdata_i : prdata_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q   <= APB_IDLE;
         wr_done_q <= 1'b0;
      end else begin
         wr_done_q <= 1'b0;
         case (state_q)
            APB_IDLE: begin
               // Setup phase seen, access phase follows
               if (psel_i && !penable_i) begin
                  state_q <= APB_WAIT_GNT;
               end
            end
            APB_WAIT_GNT: begin
               if (gnt_i) begin
                  if (pwrite_i) begin
                     wr_done_q <= 1'b1;
                     state_q   <= APB_IDLE;
                  end else begin
                     state_q <= APB_WAIT_DATA;
                  end
               end
            end
            APB_WAIT_DATA: begin
               if (rvalid_i) begin
                  state_q <= APB_IDLE;
               end
            end
            default: state_q <= APB_IDLE;
         endcase
      end
   end

   // Last read word stays on prdata after the transfer
   always_ff @(posedge clk) begin
      if (rd_done) begin
         prdata_q <= rdata_i;
      end
   end

endmodule

`default_nettype wire

//--- rtl/scan_test_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_test_consts.svh"

module scan_test_ctrl
   import sram_test_pkg::*;
(
   input  wire            clk,
   input  wire            rstn,
   input  wire            scan_en_i,
   input  wire            scan_in_i,
   input  wire            scan_load_i,
   output logic           scan_out_o,
   output logic           busy_o,
   output logic           req_o,
   output logic           we_o,
   output mem_mask_t      mask_o,
   output mem_addr_t      addr_o,
   output mem_word_t      wdata_o,
   input  wire            gnt_i,
   input  wire mem_word_t rdata_i,
   input  wire            rvalid_i
);

   localparam int ADDR_LSB = `SRAM_DATA_W;
   localparam int MASK_LSB = ADDR_LSB + `SRAM_ADDR_W;
   localparam int WE_BIT   = MASK_LSB + `SRAM_DATA_W / 8;

   logic [`SCAN_CMD_W-1:0] cmd_q;
   scan_state_t            state_q;

   // Command fields, data in the low bits
   assign wdata_o = cmd_q[ADDR_LSB-1:0];
   assign addr_o  = cmd_q[MASK_LSB-1:ADDR_LSB];
   assign mask_o  = cmd_q[WE_BIT-1:MASK_LSB];
   assign we_o    = cmd_q[WE_BIT];

   assign req_o      = (state_q == SCAN_REQ);
   assign busy_o     = (state_q != SCAN_SHIFT);
   assign scan_out_o = cmd_q[0];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cmd_q   <= '0;
         state_q <= SCAN_SHIFT;
      end else begin
         case (state_q)
            SCAN_SHIFT: begin
               if (scan_en_i) begin
                  // LSB first, bit 0 leaves on scan_out
                  cmd_q <= {scan_in_i, cmd_q[`SCAN_CMD_W-1:1]};
               end else if (scan_load_i) begin
                  state_q <= SCAN_REQ;
               end
            end
            SCAN_REQ: begin
               if (gnt_i) begin
                  state_q <= we_o ? SCAN_SHIFT : SCAN_WAIT_DATA;
               end
            end
            SCAN_WAIT_DATA: begin
               if (rvalid_i) begin
                  // Result goes into the data field for unloading
                  cmd_q[ADDR_LSB-1:0] <= rdata_i;
                  state_q             <= SCAN_SHIFT;
               end
            end
            default: state_q <= SCAN_SHIFT;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/sram_test_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_test_consts.svh"

module sram_test_top
   import sram_test_pkg::*;
(
   input  wire                    clk,
   input  wire                    rstn,
   // APB slave
   input  wire                    psel_i,
   input  wire                    penable_i,
   input  wire                    pwrite_i,
   input  wire [`SRAM_ADDR_W+1:0] paddr_i,
   input  wire mem_word_t         pwdata_i,
   input  wire mem_mask_t         pstrb_i,
   output mem_word_t              prdata_o,
   output logic                   pready_o,
   // Scan pins
   input  wire                    scan_en_i,
   input  wire                    scan_in_i,
   input  wire                    scan_load_i,
   output logic                   scan_out_o,
   output logic                   busy_o
);

   logic      req_m0, we_m0, gnt_m0, rvalid_m0;
   mem_mask_t mask_m0;
   mem_addr_t addr_m0;
   mem_word_t wdata_m0;

   logic      req_m1, we_m1, gnt_m1, rvalid_m1;
   mem_mask_t mask_m1;
   mem_addr_t addr_m1;
   mem_word_t wdata_m1;

   mem_word_t rdata;

   // Bank side of the arbiter
   logic      bank_en, bank_we, bank_rvalid;
   mem_mask_t bank_mask;
   mem_addr_t bank_addr;
   mem_word_t bank_wdata, bank_rdata;

   apb_mem_port u_apb (
      .clk       (clk),
      .rstn      (rstn),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .pstrb_i   (pstrb_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .req_o     (req_m0),
      .we_o      (we_m0),
      .mask_o    (mask_m0),
      .addr_o    (addr_m0),
      .wdata_o   (wdata_m0),
      .gnt_i     (gnt_m0),
      .rdata_i   (rdata),
      .rvalid_i  (rvalid_m0)
   );

   scan_test_ctrl u_scan (
      .clk         (clk),
      .rstn        (rstn),
      .scan_en_i   (scan_en_i),
      .scan_in_i   (scan_in_i),
      .scan_load_i (scan_load_i),
      .scan_out_o  (scan_out_o),
      .busy_o      (busy_o),
      .req_o       (req_m1),
      .we_o        (we_m1),
      .mask_o      (mask_m1),
      .addr_o      (addr_m1),
      .wdata_o     (wdata_m1),
      .gnt_i       (gnt_m1),
      .rdata_i     (rdata),
      .rvalid_i    (rvalid_m1)
   );

   port_arbiter u_arb (
      .clk         (clk),
      .rstn        (rstn),
      .req_m0_i    (req_m0),
      .we_m0_i     (we_m0),
      .mask_m0_i   (mask_m0),
      .addr_m0_i   (addr_m0),
      .wdata_m0_i  (wdata_m0),
      .gnt_m0_o    (gnt_m0),
      .rvalid_m0_o (rvalid_m0),
      .req_m1_i    (req_m1),
      .we_m1_i     (we_m1),
      .mask_m1_i   (mask_m1),
      .addr_m1_i   (addr_m1),
      .wdata_m1_i  (wdata_m1),
      .gnt_m1_o    (gnt_m1),
      .rvalid_m1_o (rvalid_m1),
      .rdata_o     (rdata),
      .en_o        (bank_en),
      .we_o        (bank_we),
      .mask_o      (bank_mask),
      .addr_o      (bank_addr),
      .wdata_o     (bank_wdata),
      .rdata_i     (bank_rdata),
      .rvalid_i    (bank_rvalid)
   );

   sram_bank u_bank (
      .clk      (clk),
      .rstn     (rstn),
      .en_i     (bank_en),
      .we_i     (bank_we),
      .mask_i   (bank_mask),
      .addr_i   (bank_addr),
      .wdata_i  (bank_wdata),
      .rdata_o  (bank_rdata),
      .rvalid_o (bank_rvalid)
   );

endmodule

`default_nettype wire

//--- tests/tb_sram_test_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_test_consts.svh"

module tb_sram_test_top
   import sram_test_pkg::*;
();

   localparam int TIMEOUT = 100;

   logic                    clk;
   logic                    rstn;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   logic [`SRAM_ADDR_W+1:0] paddr;
   mem_word_t               pwdata;
   mem_mask_t               pstrb;
   mem_word_t               prdata;
   logic                    pready;
   logic                    scan_en;
   logic                    scan_in;
   logic                    scan_load;
   logic                    scan_out;
   logic                    busy;

   int checks = 0;
   int errors = 0;

   // Expected memory contents keyed by global word address
   mem_word_t model [int];

   sram_test_top DUT (
      .clk         (clk),
      .rstn        (rstn),
      .psel_i      (psel),
      .penable_i   (penable),
      .pwrite_i    (pwrite),
      .paddr_i     (paddr),
      .pwdata_i    (pwdata),
      .pstrb_i     (pstrb),
      .prdata_o    (prdata),
      .pready_o    (pready),
      .scan_en_i   (scan_en),
      .scan_in_i   (scan_in),
      .scan_load_i (scan_load),
      .scan_out_o  (scan_out),
      .busy_o      (busy)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic void model_write(input mem_addr_t addr, input mem_word_t data,
                                       input mem_mask_t mask);
      mem_word_t word;
      int        b;
      word = model.exists(int'(addr)) ? model[int'(addr)] : 'x;
      for (b = 0; b < `SRAM_DATA_W / 8; b++) begin
         if (mask[b]) begin
            word[b*8 +: 8] = data[b*8 +: 8];
         end
      end
      model[int'(addr)] = word;
   endfunction

   function automatic mem_word_t ref_read(input mem_addr_t addr);
      return model.exists(int'(addr)) ? model[int'(addr)] : 'x;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic apb_transfer(input logic write, input mem_addr_t addr,
                               input mem_word_t wdata, input mem_mask_t strb,
                               output mem_word_t rdata);
      int n;
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = {addr, 2'b00};
      pwdata  = wdata;
      pstrb   = strb;
      // Access phase is stretched until pready
      @(negedge clk);
      penable = 1'b1;
      n = 0;
      while (!pready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!pready) begin
         errors++;
         $display("APB transfer to word %h timed out waiting for pready", addr);
      end
      rdata = prdata;
      // Transfer completes at the next rising edge
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input mem_addr_t addr, input mem_word_t data,
                            input mem_mask_t mask);
      mem_word_t unused;
      model_write(addr, data, mask);
      apb_transfer(1'b1, addr, data, mask, unused);
   endtask

   task automatic apb_read(input mem_addr_t addr, output mem_word_t data);
      apb_transfer(1'b0, addr, '0, 4'h0, data);
   endtask

   // Shifts LSB first while scan_out shows the bit about to leave
   task automatic scan_shift(input logic [`SCAN_CMD_W-1:0] cmd_in,
                             output logic [`SCAN_CMD_W-1:0] cmd_out);
      int i;
      for (i = 0; i < `SCAN_CMD_W; i++) begin
         @(negedge clk);
         cmd_out[i] = scan_out;
         scan_in    = cmd_in[i];
         scan_en    = 1'b1;
      end
      @(negedge clk);
      scan_en = 1'b0;
      scan_in = 1'b0;
   endtask

   task automatic scan_run();
      int n;
      @(negedge clk);
      scan_load = 1'b1;
      @(negedge clk);
      scan_load = 1'b0;
      check("busy_o", 32'(busy), 32'd1);
      n = 0;
      while (busy && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (busy) begin
         errors++;
         $display("Scan access timed out, busy_o never fell");
      end
   endtask

   task automatic scan_send_cmd(input logic we, input mem_mask_t mask, input mem_addr_t addr,
                                input mem_word_t data);
      logic [`SCAN_CMD_W-1:0] unused;
      if (we) begin
         model_write(addr, data, mask);
      end
      scan_shift({we, mask, addr, data}, unused);
   endtask

   // Unload the result of a scan read and compare its fields
   task automatic scan_check_read(input mem_addr_t addr);
      logic [`SCAN_CMD_W-1:0] out;
      logic                   we_f;
      mem_mask_t              mask_f;
      mem_addr_t              addr_f;
      mem_word_t              data_f;
      scan_shift('0, out);
      {we_f, mask_f, addr_f, data_f} = out;
      check("scan data field", data_f, ref_read(addr));
      check("scan addr field", 32'(addr_f), 32'(addr));
      // Read commands go in with a clear write flag and mask
      check("scan we field", 32'(we_f), 32'd0);
      check("scan mask field", 32'(mask_f), 32'd0);
   endtask

   initial begin
      mem_word_t   got;
      mem_word_t   data;
      mem_mask_t   mask;
      mem_addr_t   addr;
      mem_addr_t   a_addr;
      mem_addr_t   s_addr;
      mem_addr_t   addrs [`SRAM_NUM_MACROS];
      macro_addr_t w;
      int          m;
      int          r;
      int          i;

      void'($urandom(69));
      rstn      = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      pstrb     = '0;
      scan_en   = 1'b0;
      scan_in   = 1'b0;
      scan_load = 1'b0;
      repeat (4) @(negedge clk);
      rstn = 1'b1;

      @(negedge clk);
      check("pready_o", 32'(pready), 32'd0);
      check("busy_o", 32'(busy), 32'd0);
      check("scan_out_o", 32'(scan_out), 32'd0);

      // Same word offset in every macro so aliasing would show
      for (r = 0; r < 3; r++) begin
         w = macro_addr_t'($urandom_range(255, 0));
         for (m = 0; m < `SRAM_NUM_MACROS; m++) begin
            addrs[m] = {2'(m), w};
            apb_write(addrs[m], $urandom, 4'hf);
         end
         for (m = 0; m < `SRAM_NUM_MACROS; m++) begin
            apb_write(addrs[m], $urandom, mem_mask_t'($urandom_range(15, 0)));
         end
         for (m = 0; m < `SRAM_NUM_MACROS; m++) begin
            apb_read(addrs[m], got);
            check("prdata_o", got, ref_read(addrs[m]));
         end
      end

      // Scan write then APB read, and APB write then scan read
      for (r = 0; r < 3; r++) begin
         addr = {2'd2, macro_addr_t'($urandom_range(255, 0))};
         apb_write(addr, $urandom, 4'hf);
         scan_send_cmd(1'b1, mem_mask_t'($urandom_range(14, 1)), addr, $urandom);
         scan_run();
         apb_read(addr, got);
         check("prdata_o", got, ref_read(addr));

         addr = {2'd1, macro_addr_t'($urandom_range(255, 0))};
         apb_write(addr, $urandom, 4'hf);
         apb_write(addr, $urandom, mem_mask_t'($urandom_range(15, 0)));
         scan_send_cmd(1'b0, 4'h0, addr, '0);
         scan_run();
         scan_check_read(addr);
      end

      // Both masters start in the same cycle
      for (i = 0; i < 6; i++) begin
         a_addr = addrs[i % `SRAM_NUM_MACROS];
         s_addr = addrs[(i + 1) % `SRAM_NUM_MACROS];
         data   = $urandom;
         mask   = mem_mask_t'($urandom_range(15, 1));
         case (i % 3)
            0: begin
               scan_send_cmd(1'b0, 4'h0, s_addr, '0);
               fork
                  apb_write(a_addr, data, mask);
                  scan_run();
               join
               scan_check_read(s_addr);
            end
            1: begin
               // Two reads in flight where return routing decides the owner
               scan_send_cmd(1'b0, 4'h0, s_addr, '0);
               fork
                  apb_read(a_addr, got);
                  scan_run();
               join
               check("prdata_o", got, ref_read(a_addr));
               scan_check_read(s_addr);
            end
            default: begin
               scan_send_cmd(1'b1, mask, s_addr, data);
               fork
                  apb_read(a_addr, got);
                  scan_run();
               join
               check("prdata_o", got, ref_read(a_addr));
            end
         endcase
      end
      for (m = 0; m < `SRAM_NUM_MACROS; m++) begin
         apb_read(addrs[m], got);
         check("prdata_o", got, ref_read(addrs[m]));
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/sram_test_pkg.sv
rtl/sram_macro.sv
rtl/sram_bank.sv
rtl/port_arbiter.sv
rtl/apb_mem_port.sv
rtl/scan_test_ctrl.sv
rtl/sram_test_top.sv
tests/tb_sram_test_top.sv

//--- Makefile
TB_TOP = tb_sram_test_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module sram_test_top

sim:
	verilator --binary --timing -f flist.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
